//--- vlog.f
+incdir+verilog
verilog/mem_bus_pkg.sv
verilog/route_pkg.sv
verilog/resp_order_fifo.sv
verilog/data_port_arbiter.sv
verilog/mem_port_arbiter.sv
verilog/mem_subsys_top.sv
sim/mem_subsys_properties.sv
sim/mem_subsys_tb.sv

//--- sim/mem_subsys_tb.sv
// directed tests for the memory-side port subsystem against an in-order memory model
// model decodes byte addresses below 0x800 only; expected data comes from a reference copy

`include "arb_consts.svh"

module mem_subsys_tb;

    import mem_bus_pkg::*;

    localparam int N_MIX          = 12;  // requests per port in the mixed test
    localparam int TOTAL_REQS     = 3 + 4 + 4 + 4 + 3 * N_MIX + 12;
    localparam int TIMEOUT_CYCLES = 16 + 16 * TOTAL_REQS + 200;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   instr_req_i;
    logic [`ARB_ADDR_W-1:0] instr_addr_i;
    logic                   instr_gnt_o;
    logic                   instr_rvalid_o;
    narrow_rsp_t            instr_rsp_o;
    logic                   scalar_req_i;
    narrow_req_t            scalar_i;
    logic                   scalar_gnt_o;
    logic                   scalar_rvalid_o;
    narrow_rsp_t            scalar_rsp_o;
    logic                   vector_req_i;
    wide_req_t              vector_i;
    logic                   vector_gnt_o;
    logic                   vector_rvalid_o;
    wide_rsp_t              vector_rsp_o;
    logic                   vec_pending_load_i;
    logic                   vec_pending_store_i;
    logic                   mem_req_o;
    wide_req_t              mem_o;
    logic                   mem_rvalid_i;
    wide_rsp_t              mem_rsp_i;

    logic [`ARB_BUS_W-1:0]    mem_model [256];   // contents as the DUT sees them
    logic [`ARB_BUS_W-1:0]    ref_mem [256];     // expected contents, updated at each grant
    logic [`ARB_BUS_W-1:0]    rsp_data_q [$];
    int                       rsp_ready_q [$];   // first cycle each response may leave
    logic [`ARB_SCALAR_W-1:0] exp_instr [$];
    logic [`ARB_SCALAR_W-1:0] exp_scalar [$];
    logic [`ARB_BUS_W-1:0]    exp_vector [$];
    int                       grant_log [$];     // 1 vector, 2 scalar
    logic [31:0]              lfsr_state = 32'd90;
    logic                     hold_rsp;
    int                       cycle;
    int                       accepted;
    int                       errors;
    int                       prop_fails;        // bound assertion failures already counted
    int                       tests_run;
    int                       tests_failed;

    mem_subsys_top uut (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i]       = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // memory model

    initial begin : mem_accept
        int idx;
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = {32'h5a00_0000 ^ (i * 8 + 4), 32'hc300_0000 ^ (i * 8)};
            ref_mem[i]   = mem_model[i];
        end
        forever begin
            @(posedge clk_i);
            cycle++;
            if (mem_req_o) begin
                accepted++;
                idx = int'(mem_o.addr[10:3]);
                rsp_ready_q.push_back(cycle + 1 + int'(lfsr_bits(2)));
                if (mem_o.we) begin
                    for (int b = 0; b < 8; b++)
                        if (mem_o.be[b]) mem_model[idx][b*8 +: 8] = mem_o.wdata[b*8 +: 8];
                    rsp_data_q.push_back('0);  // write responses carry no data
                end else begin
                    rsp_data_q.push_back(mem_model[idx]);
                end
            end
        end
    end

    initial begin : mem_respond
        mem_rvalid_i = 1'b0;
        mem_rsp_i    = '0;
        forever begin
            @(negedge clk_i);
            mem_rvalid_i = 1'b0;
            if (!hold_rsp && rsp_data_q.size() > 0 && cycle >= rsp_ready_q[0]) begin
                mem_rvalid_i    = 1'b1;
                mem_rsp_i.rdata = rsp_data_q.pop_front();
                void'(rsp_ready_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // response checks

    always @(posedge clk_i) begin
        if (instr_rvalid_o) begin
            check_true(exp_instr.size() > 0, "instruction response with no fetch outstanding");
            if (exp_instr.size() > 0)
                check_value("instr_rsp_o.rdata", 64'(instr_rsp_o.rdata), 64'(exp_instr.pop_front()));
        end
        if (scalar_rvalid_o) begin
            check_true(exp_scalar.size() > 0, "scalar response with no scalar access outstanding");
            if (exp_scalar.size() > 0)
                check_value("scalar_rsp_o.rdata", 64'(scalar_rsp_o.rdata),
                            64'(exp_scalar.pop_front()));
        end
        if (vector_rvalid_o) begin
            check_true(exp_vector.size() > 0, "vector response with no vector read outstanding");
            if (exp_vector.size() > 0)
                check_value("vector_rsp_o.rdata", vector_rsp_o.rdata, exp_vector.pop_front());
        end
        // data traffic goes ahead of fetches
        check_true(!(instr_gnt_o && (vector_req_i || (scalar_req_i && !vec_pending_store_i
                   && !(vec_pending_load_i && scalar_i.we)))),
                   "instruction fetch granted while a data request was waiting");
    end

    //////////////////////////////////////////////////
    // port drivers

    task automatic fetch(input logic [31:0] addr);
        @(negedge clk_i);
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        do @(posedge clk_i); while (!instr_gnt_o);
        exp_instr.push_back(ref_mem[addr[10:3]][addr[2] * 32 +: 32]);
        @(negedge clk_i);
        instr_req_i = 1'b0;
    endtask

    task automatic scalar_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                                 input logic [3:0] be, input logic pend_ld, input logic pend_st,
                                 input int hold_n);
        logic [7:0] exp_be;
        @(negedge clk_i);
        scalar_req_i        = 1'b1;
        scalar_i            = '{addr: addr, we: we, be: be, wdata: wdata};
        vec_pending_load_i  = pend_ld;
        vec_pending_store_i = pend_st;
        repeat (hold_n) begin
            @(posedge clk_i);
            check_true(!scalar_gnt_o, "scalar request granted while the vector unit holds it off");
        end
        if (hold_n > 0) begin
            @(negedge clk_i);
            vec_pending_load_i  = 1'b0;
            vec_pending_store_i = 1'b0;
        end
        do @(posedge clk_i); while (!scalar_gnt_o);
        grant_log.push_back(2);
        if (we) begin
            exp_be = addr[2] ? {be, 4'h0} : {4'h0, be};
            check_value("mem_o.wdata", mem_o.wdata, {wdata, wdata});
            check_value("mem_o.be", 64'(mem_o.be), 64'(exp_be));
            for (int b = 0; b < 4; b++)
                if (be[b]) ref_mem[addr[10:3]][addr[2] * 32 + b * 8 +: 8] = wdata[b*8 +: 8];
            exp_scalar.push_back('0);
        end else begin
            exp_scalar.push_back(ref_mem[addr[10:3]][addr[2] * 32 +: 32]);
        end
        @(negedge clk_i);
        scalar_req_i        = 1'b0;
        vec_pending_load_i  = 1'b0;
        vec_pending_store_i = 1'b0;
    endtask

    task automatic vector_access(input logic we, input logic [31:0] addr, input logic [63:0] wdata);
        @(negedge clk_i);
        vector_req_i = 1'b1;
        vector_i     = '{addr: addr, we: we, be: '1, wdata: wdata};
        do @(posedge clk_i); while (!vector_gnt_o);
        grant_log.push_back(1);
        if (we) ref_mem[addr[10:3]] = wdata;
        else exp_vector.push_back(ref_mem[addr[10:3]]);  // writes expect no response
        @(negedge clk_i);
        vector_req_i = 1'b0;
    endtask

    task automatic random_stream(input int port, input int n);
        logic [31:0] r;
        logic [31:0] addr;
        for (int k = 0; k < n; k++) begin
            r    = lfsr_bits(6);
            addr = 32'h100 + {r[4:0], 2'b00};  // 16 bus words shared by all ports
            case (port)
                0:       fetch(addr);
                1:       scalar_access(r[5], addr, lfsr_bits(32), 4'(lfsr_bits(4)), 1'b0, 1'b0, 0);
                default: vector_access(r[5], {addr[31:3], 3'b000}, {lfsr_bits(32), lfsr_bits(32)});
            endcase
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        while (exp_instr.size() + exp_scalar.size() + exp_vector.size() + rsp_data_q.size() > 0)
            @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        errors     += uut.u_props.fail_count - prop_fails;
        prop_fails  = uut.u_props.fail_count;
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed, %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    //////////////////////////////////////////////////
    // tests

    initial begin : run_tests
        int e0;
        int base;
        rst_ni              = 1'b0;
        instr_req_i         = 1'b0;
        instr_addr_i        = '0;
        scalar_req_i        = 1'b0;
        scalar_i            = '0;
        vector_req_i        = 1'b0;
        vector_i            = '0;
        vec_pending_load_i  = 1'b0;
        vec_pending_store_i = 1'b0;
        hold_rsp            = 1'b0;
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;

        e0 = errors;
        fetch(32'h40);
        fetch(32'h44);
        fetch(32'h1fc);
        finish_test("instruction fetch", e0);

        e0 = errors;
        scalar_access(1'b1, 32'h88, 32'hdead_beef, 4'hf, 1'b0, 1'b0, 0);
        scalar_access(1'b1, 32'h8c, 32'h1234_5678, 4'h6, 1'b0, 1'b0, 0);  // middle bytes only
        scalar_access(1'b0, 32'h88, '0, 4'hf, 1'b0, 1'b0, 0);
        scalar_access(1'b0, 32'h8c, '0, 4'hf, 1'b0, 1'b0, 0);
        finish_test("scalar store and load", e0);

        e0 = errors;
        grant_log.delete();
        fork
            vector_access(1'b1, 32'hc0, 64'h0123_4567_89ab_cdef);
            scalar_access(1'b1, 32'hc4, 32'hfeed_face, 4'hf, 1'b0, 1'b0, 0);
        join
        check_true(grant_log[0] == 1, "scalar request granted ahead of a vector request");
        vector_access(1'b0, 32'hc0, '0);
        scalar_access(1'b0, 32'hc4, '0, 4'hf, 1'b0, 1'b0, 0);
        finish_test("vector priority", e0);

        e0 = errors;
        scalar_access(1'b0, 32'h88, '0, 4'hf, 1'b0, 1'b1, 5);          // held by pending store
        scalar_access(1'b0, 32'h90, '0, 4'hf, 1'b1, 1'b0, 0);          // load passes pending load
        scalar_access(1'b1, 32'h90, 32'hcafe_0001, 4'hf, 1'b1, 1'b0, 5);
        scalar_access(1'b0, 32'h90, '0, 4'hf, 1'b0, 1'b0, 0);
        finish_test("scalar hold", e0);

        e0 = errors;
        fork
            random_stream(0, N_MIX);
            random_stream(1, N_MIX);
            random_stream(2, N_MIX);
        join
        finish_test("mixed traffic", e0);

        e0 = errors;
        @(negedge clk_i);
        hold_rsp = 1'b1;
        base     = accepted;
        fork
            random_stream(0, 6);
            random_stream(1, 6);
            begin
                while (accepted - base < 8) @(negedge clk_i);
                repeat (10) begin
                    @(posedge clk_i);
                    check_true(!mem_req_o, "memory request issued while the route queue was full");
                end
                @(negedge clk_i);
                check_value("accepted requests", 64'(accepted - base), 64'd8);
                hold_rsp = 1'b0;
            end
        join
        finish_test("back-pressure", e0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim/mem_subsys_properties.sv
// handshake properties of the three requester ports, bound into the top level
// checks are off while reset is asserted

`include "arb_consts.svh"

module mem_subsys_properties (
    input logic                     clk_i,
    input logic                     rst_ni,
    input logic                     instr_req_i,
    input logic [`ARB_ADDR_W-1:0]   instr_addr_i,
    input logic                     instr_gnt_o,
    input logic                     scalar_req_i,
    input mem_bus_pkg::narrow_req_t scalar_i,
    input logic                     scalar_gnt_o,
    input logic                     vector_req_i,
    input mem_bus_pkg::wide_req_t   vector_i,
    input logic                     vector_gnt_o
);

    int fail_count = 0;  // failed assertions so far

    // no grant without a request
    a_instr_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_gnt_o |-> instr_req_i)
        else begin
            $error("instruction grant without a request");
            fail_count++;
        end
    a_scalar_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        scalar_gnt_o |-> scalar_req_i)
        else begin
            $error("scalar grant without a request");
            fail_count++;
        end
    a_vector_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        vector_gnt_o |-> vector_req_i)
        else begin
            $error("vector grant without a request");
            fail_count++;
        end

    a_data_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(scalar_gnt_o && vector_gnt_o))
        else begin
            $error("scalar and vector granted together");
            fail_count++;
        end
    a_mem_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(instr_gnt_o && (scalar_gnt_o || vector_gnt_o)))  // data grant is scalar or vector
        else begin
            $error("instruction and data granted together");
            fail_count++;
        end

    // requester side of the handshake
    a_instr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_req_i && !instr_gnt_o |=> instr_req_i && $stable(instr_addr_i))
        else begin
            $error("fetch request dropped or changed before its grant");
            fail_count++;
        end
    a_scalar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        scalar_req_i && !scalar_gnt_o |=> scalar_req_i && $stable(scalar_i))
        else begin
            $error("scalar request dropped or changed before its grant");
            fail_count++;
        end
    a_vector_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        vector_req_i && !vector_gnt_o |=> vector_req_i && $stable(vector_i))
        else begin
            $error("vector request dropped or changed before its grant");
            fail_count++;
        end

endmodule

bind mem_subsys_top mem_subsys_properties u_props (.*);

//--- verilog/mem_subsys_top.sv
// memory-side ports of the vector processor system: fetch, scalar data, vector data
// vector port width equals the memory bus width (no caches)

`include "arb_consts.svh"

module mem_subsys_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    input  logic                     instr_req_i,
    input  logic [`ARB_ADDR_W-1:0]   instr_addr_i,
    output logic                     instr_gnt_o,
    output logic                     instr_rvalid_o,
    output mem_bus_pkg::narrow_rsp_t instr_rsp_o,

    input  logic                     scalar_req_i,
    input  mem_bus_pkg::narrow_req_t scalar_i,
    output logic                     scalar_gnt_o,
    output logic                     scalar_rvalid_o,
    output mem_bus_pkg::narrow_rsp_t scalar_rsp_o,

    input  logic                     vector_req_i,
    input  mem_bus_pkg::wide_req_t   vector_i,
    output logic                     vector_gnt_o,
    output logic                     vector_rvalid_o,
    output mem_bus_pkg::wide_rsp_t   vector_rsp_o,
    input  logic                     vec_pending_load_i,
    input  logic                     vec_pending_store_i,

    output logic                     mem_req_o,
    output mem_bus_pkg::wide_req_t   mem_o,
    input  logic                     mem_rvalid_i,
    input  mem_bus_pkg::wide_rsp_t   mem_rsp_i
);

    import mem_bus_pkg::*;

    // merged data port between the two arbiters
    logic      data_req;
    logic      data_gnt;
    logic      data_rvalid;
    wide_req_t data_bus;
    wide_rsp_t data_rsp;

    data_port_arbiter u_data_arb (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .scalar_req_i        ( scalar_req_i        ),
        .scalar_i            ( scalar_i            ),
        .scalar_gnt_o        ( scalar_gnt_o        ),
        .scalar_rvalid_o     ( scalar_rvalid_o     ),
        .scalar_rsp_o        ( scalar_rsp_o        ),
        .vector_req_i        ( vector_req_i        ),
        .vector_i            ( vector_i            ),
        .vector_gnt_o        ( vector_gnt_o        ),
        .vector_rvalid_o     ( vector_rvalid_o     ),
        .vector_rsp_o        ( vector_rsp_o        ),
        .vec_pending_load_i  ( vec_pending_load_i  ),
        .vec_pending_store_i ( vec_pending_store_i ),
        .down_req_o          ( data_req            ),
        .down_o              ( data_bus            ),
        .down_gnt_i          ( data_gnt            ),
        .down_rvalid_i       ( data_rvalid         ),
        .down_rsp_i          ( data_rsp            )
    );

    mem_port_arbiter u_mem_arb (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .data_req_i     ( data_req       ),
        .data_i         ( data_bus       ),
        .data_gnt_o     ( data_gnt       ),
        .data_rvalid_o  ( data_rvalid    ),
        .data_rsp_o     ( data_rsp       ),
        .instr_req_i    ( instr_req_i    ),
        .instr_addr_i   ( instr_addr_i   ),
        .instr_gnt_o    ( instr_gnt_o    ),
        .instr_rvalid_o ( instr_rvalid_o ),
        .instr_rsp_o    ( instr_rsp_o    ),
        .mem_req_o      ( mem_req_o      ),
        .mem_o          ( mem_o          ),
        .mem_rvalid_i   ( mem_rvalid_i   ),
        .mem_rsp_i      ( mem_rsp_i      )
    );

endmodule

//--- verilog/mem_port_arbiter.sv
// data and instruction ports onto the external memory bus, data first
// no external grant: mem_req_o is an accepted request; memory answers reads and writes in order

`include "arb_consts.svh"

module mem_port_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    input  logic                     data_req_i,
    input  mem_bus_pkg::wide_req_t   data_i,
    output logic                     data_gnt_o,
    output logic                     data_rvalid_o,
    output mem_bus_pkg::wide_rsp_t   data_rsp_o,

    input  logic                     instr_req_i,
    input  logic [`ARB_ADDR_W-1:0]   instr_addr_i,
    output logic                     instr_gnt_o,
    output logic                     instr_rvalid_o,
    output mem_bus_pkg::narrow_rsp_t instr_rsp_o,

    output logic                     mem_req_o,
    output mem_bus_pkg::wide_req_t   mem_o,
    input  logic                     mem_rvalid_i,
    input  mem_bus_pkg::wide_rsp_t   mem_rsp_i
);

    import mem_bus_pkg::*;
    import route_pkg::*;

    logic       q_full;
    logic       q_empty;
    logic       rsp_live;
    mem_route_t push_route;
    mem_route_t head_route;

    //////////////////////////////////////////////////
    // request side

    assign data_gnt_o  = data_req_i & ~q_full;
    assign instr_gnt_o = instr_req_i & ~data_req_i & ~q_full;
    assign mem_req_o   = data_gnt_o | instr_gnt_o;

    // fetches go out as full-width reads
    always_comb begin
        mem_o.addr  = instr_addr_i;
        mem_o.we    = 1'b0;
        mem_o.be    = '1;
        mem_o.wdata = '0;
        if (data_req_i) begin
            mem_o = data_i;
        end
    end

    assign push_route.is_data = data_req_i;
    assign push_route.lane    = lane_of(instr_addr_i);  // only read back for fetches

    resp_order_fifo #(
        .entry_t      ( mem_route_t      ),
        .DEPTH        ( `ARB_ROUTE_DEPTH )
    ) u_route_q (
        .clk_i        ( clk_i            ),
        .rst_ni       ( rst_ni           ),
        .push_i       ( mem_req_o        ),
        .push_entry_i ( push_route       ),
        .pop_i        ( mem_rvalid_i     ),
        .head_o       ( head_route       ),
        .full_o       ( q_full           ),
        .empty_o      ( q_empty          )
    );

    //////////////////////////////////////////////////
    // response side

    assign rsp_live = mem_rvalid_i & ~q_empty;

    assign data_rvalid_o     = rsp_live & head_route.is_data;
    assign instr_rvalid_o    = rsp_live & ~head_route.is_data;
    assign data_rsp_o        = mem_rsp_i;
    assign instr_rsp_o.rdata = lane_word(mem_rsp_i.rdata, head_route.lane);
    assign instr_rsp_o.err   = mem_rsp_i.err;

endmodule

//--- verilog/data_port_arbiter.sv
// scalar + vector data ports onto one wide data port, vector first
// vector writes get no response; every other granted request gets exactly one
// assumes the downstream port answers in grant order

`include "arb_consts.svh"

module data_port_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    input  logic                     scalar_req_i,
    input  mem_bus_pkg::narrow_req_t scalar_i,
    output logic                     scalar_gnt_o,
    output logic                     scalar_rvalid_o,
    output mem_bus_pkg::narrow_rsp_t scalar_rsp_o,

    input  logic                     vector_req_i,
    input  mem_bus_pkg::wide_req_t   vector_i,
    output logic                     vector_gnt_o,
    output logic                     vector_rvalid_o,
    output mem_bus_pkg::wide_rsp_t   vector_rsp_o,

    input  logic                     vec_pending_load_i,
    input  logic                     vec_pending_store_i,

    output logic                     down_req_o,
    output mem_bus_pkg::wide_req_t   down_o,
    input  logic                     down_gnt_i,
    input  logic                     down_rvalid_i,
    input  mem_bus_pkg::wide_rsp_t   down_rsp_i
);

    import mem_bus_pkg::*;
    import route_pkg::*;

    logic        scalar_hold;
    logic        scalar_sel;
    lane_t       scalar_lane;
    logic        q_full;
    logic        q_empty;
    logic        q_push;
    logic        rsp_live;
    data_route_t push_route;
    data_route_t head_route;

    //////////////////////////////////////////////////
    // request side

    // keep scalar accesses out of the way of vector memory traffic
    assign scalar_hold = vector_req_i | vec_pending_store_i
                       | (vec_pending_load_i & scalar_i.we);
    assign scalar_sel  = scalar_req_i & ~scalar_hold;
    assign scalar_lane = lane_of(scalar_i.addr);

    assign down_req_o  = (vector_req_i | scalar_sel) & ~q_full;

    always_comb begin
        down_o.addr  = scalar_i.addr;
        down_o.we    = scalar_i.we;
        down_o.be    = '0;
        down_o.be[scalar_lane * (`ARB_SCALAR_W / 8) +: `ARB_SCALAR_W / 8] = scalar_i.be;
        down_o.wdata = {`ARB_LANES{scalar_i.wdata}};  // same word in every lane
        if (vector_req_i) begin
            down_o = vector_i;
        end
    end

    assign vector_gnt_o = down_gnt_i & vector_req_i & ~q_full;
    assign scalar_gnt_o = down_gnt_i & scalar_sel & ~q_full;
    assign q_push       = vector_gnt_o | scalar_gnt_o;

    assign push_route.is_vector = vector_req_i;
    assign push_route.is_write  = vector_req_i ? vector_i.we : scalar_i.we;
    assign push_route.lane      = scalar_lane;

    resp_order_fifo #(
        .entry_t      ( data_route_t     ),
        .DEPTH        ( `ARB_ROUTE_DEPTH )
    ) u_route_q (
        .clk_i        ( clk_i            ),
        .rst_ni       ( rst_ni           ),
        .push_i       ( q_push           ),
        .push_entry_i ( push_route       ),
        .pop_i        ( down_rvalid_i    ),
        .head_o       ( head_route       ),
        .full_o       ( q_full           ),
        .empty_o      ( q_empty          )
    );

    //////////////////////////////////////////////////
    // response side

    assign rsp_live = down_rvalid_i & ~q_empty;

    assign scalar_rvalid_o    = rsp_live & ~head_route.is_vector;
    assign vector_rvalid_o    = rsp_live & head_route.is_vector & ~head_route.is_write;
    assign scalar_rsp_o.rdata = lane_word(down_rsp_i.rdata, head_route.lane);
    assign scalar_rsp_o.err   = down_rsp_i.err;
    assign vector_rsp_o       = down_rsp_i;

endmodule

//--- verilog/resp_order_fifo.sv
// in-order queue of route entries, one per granted request
// push is dropped when full unless a pop happens in the same cycle; pop when empty is ignored
// head_o is undefined while empty

module resp_order_fifo #(
    parameter type         entry_t = logic,
    parameter int unsigned DEPTH   = 2
) (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   push_i,
    input  entry_t push_entry_i,
    input  logic   pop_i,
    output entry_t head_o,
    output logic   full_o,
    output logic   empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    entry_t           store_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_pop  = pop_i & ~empty_o;
    assign do_push = push_i & (~full_o | do_pop);  // full queue still takes push with pop

    assign head_o  = store_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            store_q[wr_ptr_q] <= push_entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- verilog/route_pkg.sv
// route entries kept per outstanding request, plus lane helpers
// lane index comes from the address bits just above the scalar word offset

`include "arb_consts.svh"

package route_pkg;

    typedef logic [`ARB_LANE_W-1:0] lane_t;

    // data arbiter: who asked, and does a response come back at all
    typedef struct packed {
        logic  is_vector;
        logic  is_write;
        lane_t lane;      // scalar word position in the bus
    } data_route_t;

    // memory arbiter: data port or instruction fetch
    typedef struct packed {
        logic  is_data;
        lane_t lane;
    } mem_route_t;

    function automatic lane_t lane_of(logic [`ARB_ADDR_W-1:0] addr);
        return addr[`ARB_LANE_LSB +: `ARB_LANE_W];
    endfunction

    // pick one scalar word out of a full bus beat
    function automatic logic [`ARB_SCALAR_W-1:0] lane_word(logic [`ARB_BUS_W-1:0] data,
                                                            lane_t lane);
        return data[lane * `ARB_SCALAR_W +: `ARB_SCALAR_W];
    endfunction

endpackage

//--- verilog/mem_bus_pkg.sv
// request and response payloads of the wide and narrow memory ports
// control (req, gnt, rvalid) travels beside these structs, not inside them

`include "arb_consts.svh"

package mem_bus_pkg;

    //////////////////////////////////////////////////
    // wide port, memory bus and vector unit

    typedef struct packed {
        logic [`ARB_ADDR_W-1:0]  addr;
        logic                    we;
        logic [`ARB_BUS_W/8-1:0] be;    // one per byte
        logic [`ARB_BUS_W-1:0]   wdata;
    } wide_req_t;

    typedef struct packed {
        logic [`ARB_BUS_W-1:0] rdata;
        logic                  err;
    } wide_rsp_t;

    //////////////////////////////////////////////////
    // narrow port, scalar core

    typedef struct packed {
        logic [`ARB_ADDR_W-1:0]     addr;
        logic                       we;
        logic [`ARB_SCALAR_W/8-1:0] be;
        logic [`ARB_SCALAR_W-1:0]   wdata;
    } narrow_req_t;

    typedef struct packed {
        logic [`ARB_SCALAR_W-1:0] rdata;
        logic                     err;
    } narrow_rsp_t;

endpackage

//--- verilog/arb_consts.svh
// widths and queue depth shared by the memory-side port subsystem
// bus width must be a power-of-two multiple of the scalar width (at least two lanes)
`ifndef ARB_CONSTS_SVH
`define ARB_CONSTS_SVH

// byte address width of every port
`define ARB_ADDR_W 32

// external memory bus and vector port data width
`define ARB_BUS_W 64

// scalar core word width
`define ARB_SCALAR_W 32

// outstanding requests each route queue can track
`define ARB_ROUTE_DEPTH 8

// derived lane geometry
`define ARB_LANES    (`ARB_BUS_W / `ARB_SCALAR_W)
`define ARB_LANE_W   $clog2(`ARB_LANES)
`define ARB_LANE_LSB $clog2(`ARB_SCALAR_W / 8)

`endif
